// ==== design/alu_fu.sv ====
/* single-cycle integer unit for ADD, SUB, AND and XOR
   the result sits in an output register until the arbiter takes it */

`include "ooo_macros.svh"

module alu_fu (
    input  logic    clk,
    input  logic    rst_n,
    fu_issue_if.fu  issue,
    fu_result_if.fu result
);
    logic                  res_valid;
    logic [`OOO_TAG_W-1:0] res_tag;
    logic [`OOO_XLEN-1:0]  res_value;
    logic [`OOO_XLEN-1:0]  alu_out;
    logic                  take;

    always_comb begin
        case (issue.op)
            ooo_pkg::OP_SUB: alu_out = issue.a - issue.b;
            ooo_pkg::OP_AND: alu_out = issue.a & issue.b;
            ooo_pkg::OP_XOR: alu_out = issue.a ^ issue.b;
            default:         alu_out = issue.a + issue.b;
        endcase
    end

    // free when empty or when the held result leaves this cycle
    assign issue.ready = !res_valid || result.ready;
    assign take        = issue.valid && issue.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (take) begin
            res_valid <= 1'b1;
        end else if (result.ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            res_tag   <= issue.tag;
            res_value <= alu_out;
        end
    end

    assign result.valid = res_valid;
    assign result.tag   = res_tag;
    assign result.value = res_value;

endmodule

// ==== design/booth_mul_fu.sv ====
/* iterative radix-2 booth multiplier returning the low word
   one operation in flight and its result held until the arbiter takes it */

`include "ooo_macros.svh"

module booth_mul_fu (
    input  logic    clk,
    input  logic    rst_n,
    fu_issue_if.fu  issue,
    fu_result_if.fu result
);
    localparam int XLEN  = `OOO_XLEN;
    localparam int CNT_W = $clog2(`OOO_MUL_STEPS + 1);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`OOO_MUL_STEPS);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

    mul_state_t            state;
    logic [CNT_W-1:0]      count;
    logic [XLEN:0]         acc;
    logic [XLEN:0]         mcand;
    logic [XLEN-1:0]       mplier;
    logic                  q_m1;
    logic [`OOO_TAG_W-1:0] tag_q;
    logic [XLEN:0]         sum;
    logic                  accept;
    logic                  step;

    assign issue.ready = (state == MUL_IDLE);
    assign accept      = issue.valid && issue.ready;
    assign step        = (state == MUL_RUN) && (count != LAST_STEP);

    // ------------------------------------------------------------------
    // booth recoding of the current multiplier bit pair
    // ------------------------------------------------------------------
    always_comb begin
        case ({mplier[0], q_m1})
            2'b01:   sum = acc + mcand;
            2'b10:   sum = acc - mcand;
            default: sum = acc;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MUL_IDLE;
            count <= '0;
        end else begin
            case (state)
                MUL_IDLE: begin
                    if (accept) begin
                        state <= MUL_RUN;
                        count <= '0;
                    end
                end
                MUL_RUN: begin
                    // one extra cycle after the last step before valid
                    if (step) begin
                        count <= count + 1'b1;
                    end else begin
                        state <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (result.ready) begin
                        state <= MUL_IDLE;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    // acc is one bit wider so that subtracting the most negative value cannot overflow
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            mcand  <= {issue.a[XLEN-1], issue.a};
            mplier <= issue.b;
            q_m1   <= 1'b0;
            tag_q  <= issue.tag;
        end else if (step) begin
            // arithmetic shift right of {acc, mplier, q_m1}
            acc    <= {sum[XLEN], sum[XLEN:1]};
            mplier <= {sum[0], mplier[XLEN-1:1]};
            q_m1   <= mplier[0];
        end
    end

    assign result.valid = (state == MUL_DONE);
    assign result.tag   = tag_q;
    assign result.value = mplier;

endmodule

// ==== design/cdb_arbiter.sv ====
/* puts one unit result per cycle on the common data bus
   multiplier has priority and the ALU goes when the multiplier is idle */

module cdb_arbiter (
    fu_result_if.arb             alu_res,
    fu_result_if.arb             mul_res,
    output ooo_pkg::cdb_packet_t cdb
);

    always_comb begin
        // the ROB always accepts, so the winner is taken at once
        mul_res.ready = mul_res.valid;
        alu_res.ready = alu_res.valid && !mul_res.valid;

        cdb.valid = mul_res.valid || alu_res.valid;
        if (mul_res.valid) begin
            cdb.tag   = mul_res.tag;
            cdb.value = mul_res.value;
        end else begin
            cdb.tag   = alu_res.tag;
            cdb.value = alu_res.value;
        end
    end

endmodule

// ==== design/fu_if.sv ====
/* dispatch and result handshakes of a functional unit
   one pair per unit with the ROB side on issue and the arbiter side on result */

`include "ooo_macros.svh"

interface fu_issue_if;
    logic                  valid;
    logic                  ready;
    logic [`OOO_TAG_W-1:0] tag;
    ooo_pkg::op_t          op;
    logic [`OOO_XLEN-1:0]  a;
    logic [`OOO_XLEN-1:0]  b;

    modport rob (output valid, output tag, output op, output a, output b, input ready);
    modport fu  (input valid, input tag, input op, input a, input b, output ready);
endinterface

interface fu_result_if;
    logic                  valid;
    logic                  ready;
    logic [`OOO_TAG_W-1:0] tag;
    logic [`OOO_XLEN-1:0]  value;

    modport fu  (output valid, output tag, output value, input ready);
    modport arb (input valid, input tag, input value, output ready);
endinterface

// ==== design/ooo_core.sv ====
/* top level of the out-of-order back end
   dispatch in with resolved operands, in-order commit out */

`include "ooo_macros.svh"

module ooo_core (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  ooo_pkg::op_t          issue_op,
    input  logic [`OOO_REG_W-1:0] issue_rd,
    input  logic [`OOO_XLEN-1:0]  issue_a,
    input  logic [`OOO_XLEN-1:0]  issue_b,
    output logic                  commit_valid,
    output logic [`OOO_REG_W-1:0] commit_rd,
    output logic [`OOO_XLEN-1:0]  commit_value
);

    // rob to unit dispatch channels
    fu_issue_if  alu_issue_if ();
    fu_issue_if  mul_issue_if ();

    // unit to arbiter result channels
    fu_result_if alu_result_if ();
    fu_result_if mul_result_if ();

    ooo_pkg::cdb_packet_t cdb;

    reorder_buffer rob (
        .clk,
        .rst_n,
        .issue_valid,
        .issue_ready,
        .issue_op,
        .issue_rd,
        .issue_a,
        .issue_b,
        .alu_issue    (alu_issue_if.rob),
        .mul_issue    (mul_issue_if.rob),
        .cdb,
        .commit_valid,
        .commit_rd,
        .commit_value
    );

    alu_fu alu (
        .clk,
        .rst_n,
        .issue  (alu_issue_if.fu),
        .result (alu_result_if.fu)
    );

    // booth multiplier with one operation at a time
    booth_mul_fu mul (
        .clk,
        .rst_n,
        .issue  (mul_issue_if.fu),
        .result (mul_result_if.fu)
    );

    cdb_arbiter arb (
        .alu_res (alu_result_if.arb),
        .mul_res (mul_result_if.arb),
        .cdb
    );

endmodule

// ==== design/ooo_macros.svh ====
/* widths and sizes shared by the back end
   include this in any file that sizes a port, register or counter */

`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// data path width
`define OOO_XLEN 32

// reorder buffer entries and the tag that names one of them
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W 3

// architectural register index
`define OOO_REG_W 5

// radix-2 booth needs one step per multiplier bit
`define OOO_MUL_STEPS 32

`endif

// ==== design/ooo_pkg.sv ====
/* opcode and packet types for the back end
   referenced by scoped name from the ROB, the units and the arbiter */

`include "ooo_macros.svh"

package ooo_pkg;

    // operations accepted at dispatch
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } op_t;

    // one result broadcast on the common data bus
    typedef struct packed {
        logic                  valid;
        logic [`OOO_TAG_W-1:0] tag;
        logic [`OOO_XLEN-1:0]  value;
    } cdb_packet_t;

    // per-operation state held in the reorder buffer
    typedef struct packed {
        logic [`OOO_REG_W-1:0] rd;
        logic                  done;
        logic [`OOO_XLEN-1:0]  value;
    } rob_entry_t;

endpackage

// ==== design/reorder_buffer.sv ====
/* circular reorder buffer that hands out tags, steers dispatch to a unit,
   records CDB results by tag and retires them in program order */

`include "ooo_macros.svh"

module reorder_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_valid,
    output logic                  issue_ready,
    input  ooo_pkg::op_t          issue_op,
    input  logic [`OOO_REG_W-1:0] issue_rd,
    input  logic [`OOO_XLEN-1:0]  issue_a,
    input  logic [`OOO_XLEN-1:0]  issue_b,
    fu_issue_if.rob               alu_issue,
    fu_issue_if.rob               mul_issue,
    input  ooo_pkg::cdb_packet_t  cdb,
    output logic                  commit_valid,
    output logic [`OOO_REG_W-1:0] commit_rd,
    output logic [`OOO_XLEN-1:0]  commit_value
);
    localparam int TAG_W = `OOO_TAG_W;
    localparam int CNT_W = `OOO_TAG_W + 1;
    localparam logic [TAG_W-1:0] LAST_IDX = TAG_W'(`OOO_ROB_DEPTH - 1);
    localparam logic [CNT_W-1:0] DEPTH    = CNT_W'(`OOO_ROB_DEPTH);

    ooo_pkg::rob_entry_t entries [`OOO_ROB_DEPTH];

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             is_mul;
    logic             unit_ready;
    logic             accept;

    // ------------------------------------------------------------------
    // dispatch steering
    // ------------------------------------------------------------------
    assign full       = (count == DEPTH);
    assign is_mul     = (issue_op == ooo_pkg::OP_MUL);
    assign unit_ready = is_mul ? mul_issue.ready : alu_issue.ready;
    assign issue_ready = !full && unit_ready;
    assign accept     = issue_valid && issue_ready;

    // the tail tag goes out with the operation at the accepting edge
    assign alu_issue.valid = issue_valid && !full && !is_mul;
    assign alu_issue.tag   = tail;
    assign alu_issue.op    = issue_op;
    assign alu_issue.a     = issue_a;
    assign alu_issue.b     = issue_b;

    assign mul_issue.valid = issue_valid && !full && is_mul;
    assign mul_issue.tag   = tail;
    assign mul_issue.op    = issue_op;
    assign mul_issue.a     = issue_a;
    assign mul_issue.b     = issue_b;

    // ------------------------------------------------------------------
    // commit from the head entry
    // ------------------------------------------------------------------
    assign commit_valid = (count != '0) && entries[head].done;
    assign commit_rd    = entries[head].rd;
    assign commit_value = entries[head].value;

    // allocation and CDB write never hit the same slot
    always_ff @(posedge clk) begin
        if (accept) begin
            entries[tail].rd   <= issue_rd;
            entries[tail].done <= 1'b0;
        end
        if (cdb.valid) begin
            entries[cdb.tag].done  <= 1'b1;
            entries[cdb.tag].value <= cdb.value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= (tail == LAST_IDX) ? '0 : tail + 1'b1;
            end
            if (commit_valid) begin
                head <= (head == LAST_IDX) ? '0 : head + 1'b1;
            end
            case ({accept, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== ooo_core.f ====
+incdir+design
design/ooo_pkg.sv
design/fu_if.sv
design/reorder_buffer.sv
design/alu_fu.sv
design/booth_mul_fu.sv
design/cdb_arbiter.sv
design/ooo_core.sv
testbench/tb_clock.sv
testbench/tb_ooo_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the back end and its testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f ooo_core.f \
    --top-module tb_ooo_core \
    -Mdir obj_dir \
    -o sim_ooo_core

./obj_dir/sim_ooo_core | tee sim.log

# the simulator exits cleanly on a failed check too, so the log decides
if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== testbench/ooo_trace.txt ====
// one operation per line, all fields hex, ffffffff as opcode ends the trace
// opcode (0 add, 1 sub, 2 and, 3 xor, 4 mul)  rd  operand a  operand b  expected result
0 01 00000005 00000007 0000000c
1 02 00000003 00000005 fffffffe
2 03 f0f0f0f0 0ff00ff0 00f000f0
3 04 aaaaaaaa 55555555 ffffffff
0 05 ffffffff 00000001 00000000
1 06 80000000 00000001 7fffffff
// mul then alu ops that finish first but must commit after it
4 07 00000006 00000007 0000002a
0 08 00000010 00000020 00000030
1 09 00000064 00000001 00000063
3 0a 12345678 ffffffff edcba987
2 0b deadbeef 0000ffff 0000beef
// negative operands and range extremes
4 0c fffffffd 00000005 fffffff1
4 0d fffffffe fffffffd 00000006
4 0e 7fffffff 7fffffff 00000001
4 0f 80000000 80000000 00000000
4 10 80000000 ffffffff 80000000
4 11 7fffffff 80000000 80000000
0 12 00000001 00000002 00000003
0 13 7fffffff 00000001 80000000
1 14 00000000 00000001 ffffffff
2 15 ffffffff 12345678 12345678
3 16 0000ffff 00ff00ff 00ffff00
4 17 00001234 00010000 12340000
0 18 80000000 80000000 00000000
1 19 00000005 00000003 00000002
ffffffff 00 00000000 00000000 00000000

// ==== testbench/tb_clock.sv ====
/* clock and reset source for the testbench
   4 ns clock, reset held low for the first 10 rising edges */

module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== testbench/tb_ooo_core.sv ====
/* testbench for the out-of-order back end
   replays the operation trace through dispatch and checks each commit in program order */

`include "ooo_macros.svh"

module tb_ooo_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          MAX_OPS      = 64;
    localparam int          WORDS        = 5;
    localparam int          PASSES       = 2;
    localparam int          ROB_DEPTH    = `OOO_ROB_DEPTH;
    localparam int          DRAIN_CYCLES = 20;
    localparam logic [31:0] END_MARK     = 32'hffffffff;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    logic                  issue_ready;
    ooo_pkg::op_t          issue_op;
    logic [`OOO_REG_W-1:0] issue_rd;
    logic [`OOO_XLEN-1:0]  issue_a;
    logic [`OOO_XLEN-1:0]  issue_b;
    logic                  commit_valid;
    logic [`OOO_REG_W-1:0] commit_rd;
    logic [`OOO_XLEN-1:0]  commit_value;

    // raw trace words with five per operation
    logic [31:0]           trace_mem [0:WORDS*MAX_OPS-1];
    ooo_pkg::op_t          op_arr    [MAX_OPS];
    logic [`OOO_REG_W-1:0] rd_arr    [MAX_OPS];
    logic [`OOO_XLEN-1:0]  a_arr     [MAX_OPS];
    logic [`OOO_XLEN-1:0]  b_arr     [MAX_OPS];
    logic [`OOO_XLEN-1:0]  exp_arr   [MAX_OPS];

    int n_ops;
    int total_ops;
    int error_count;
    int accept_count;
    int commit_count;
    int peak_in_flight;
    int cycle_count;
    int cycle_limit;
    bit trace_loaded;

    // trace indices of accepted operations, oldest first
    int expected_q [$];

    tb_clock clock_gen (
        .clk,
        .rst_n
    );

    ooo_core DUT (
        .clk,
        .rst_n,
        .issue_valid,
        .issue_ready,
        .issue_op,
        .issue_rd,
        .issue_a,
        .issue_b,
        .commit_valid,
        .commit_rd,
        .commit_value
    );

    // ------------------------------------------------------------------
    // trace loading and dispatch
    // ------------------------------------------------------------------
    task automatic load_trace();
        int          i;
        bit          at_end;
        logic [31:0] opcode;
        $readmemh("testbench/ooo_trace.txt", trace_mem);
        n_ops  = 0;
        at_end = 1'b0;
        for (i = 0; i < MAX_OPS; i++) begin
            opcode = trace_mem[WORDS*i];
            if (!at_end && opcode == END_MARK) begin
                at_end = 1'b1;
            end else if (!at_end) begin
                if (opcode > 32'd4) begin
                    $display("trace entry %0d has an unknown opcode %h", i, opcode);
                    error_count++;
                end
                op_arr[n_ops]  = ooo_pkg::op_t'(opcode[2:0]);
                rd_arr[n_ops]  = trace_mem[WORDS*i+1][`OOO_REG_W-1:0];
                a_arr[n_ops]   = trace_mem[WORDS*i+2];
                b_arr[n_ops]   = trace_mem[WORDS*i+3];
                exp_arr[n_ops] = trace_mem[WORDS*i+4];
                n_ops++;
            end
        end
    endtask

    // two passes put the last MUL ahead of more ALU ops than the ROB holds
    task automatic drive_trace();
        int pass;
        int i;
        for (pass = 0; pass < PASSES; pass++) begin
            for (i = 0; i < n_ops; i++) begin
                @(posedge clk);
                issue_valid <= 1'b1;
                issue_op    <= op_arr[i];
                issue_rd    <= rd_arr[i];
                issue_a     <= a_arr[i];
                issue_b     <= b_arr[i];
                // held until ready is seen and the ROB takes it at the next rising edge
                @(negedge clk);
                while (!issue_ready) begin
                    @(negedge clk);
                end
            end
        end
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // commit checking
    // ------------------------------------------------------------------
    task automatic check_commit();
        int idx;
        if (expected_q.size() == 0) begin
            $display("commit at %0t with no operation outstanding", $time);
            error_count++;
        end else begin
            idx = expected_q.pop_front();
            if (commit_rd !== rd_arr[idx]) begin
                $display("[FAIL] t=%0t commit_rd expected %0d actual %0d (trace op %0d)",
                         $time, rd_arr[idx], commit_rd, idx);
                error_count++;
            end
            if (commit_value !== exp_arr[idx]) begin
                $display("[FAIL] t=%0t commit_value expected %h actual %h (trace op %0d)",
                         $time, exp_arr[idx], commit_value, idx);
                error_count++;
            end
        end
        commit_count++;
    endtask

    // outputs are sampled mid-cycle and the transfer itself is at the next rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (commit_valid) begin
                $display("[FAIL] t=%0t commit_valid expected 0 actual 1", $time);
                error_count++;
            end
        end else begin
            // a full ROB takes nothing
            if (accept_count - commit_count >= ROB_DEPTH && issue_ready) begin
                $display("[FAIL] t=%0t issue_ready expected 0 actual 1 (ROB full)", $time);
                error_count++;
            end
            if (issue_valid && issue_ready) begin
                expected_q.push_back(accept_count % n_ops);
                accept_count++;
            end
            if (commit_valid) begin
                check_commit();
            end
            if (accept_count - commit_count > peak_in_flight) begin
                peak_in_flight = accept_count - commit_count;
            end
            if (accept_count - commit_count > ROB_DEPTH) begin
                $display("more than %0d operations in flight at %0t", ROB_DEPTH, $time);
                error_count++;
            end
        end
    end

    task automatic finish_run(input bit timed_out);
        $display("errors %0d, commits %0d of %0d operations",
                 error_count, commit_count, total_ops);
        if (error_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    // ------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        issue_valid <= 1'b0;
        issue_op    <= ooo_pkg::OP_ADD;
        issue_rd    <= '0;
        issue_a     <= '0;
        issue_b     <= '0;
        error_count    = 0;
        accept_count   = 0;
        commit_count   = 0;
        peak_in_flight = 0;
        load_trace();
        total_ops    = PASSES * n_ops;
        cycle_limit  = 40 * total_ops + 200;
        trace_loaded = 1'b1;
        if (n_ops == 0) begin
            $display("no operations found in the trace file");
            error_count++;
        end else begin
            wait (rst_n === 1'b1);
            drive_trace();
            wait (commit_count >= total_ops);
            // idle a while so that a stray extra commit shows up
            repeat (DRAIN_CYCLES) @(posedge clk);
            if (accept_count != total_ops) begin
                $display("accepted %0d operations but %0d were issued",
                         accept_count, total_ops);
                error_count++;
            end
            if (expected_q.size() != 0) begin
                $display("%0d operations never committed", expected_q.size());
                error_count++;
            end
            if (peak_in_flight < ROB_DEPTH) begin
                $display("the ROB never held %0d operations, at most %0d",
                         ROB_DEPTH, peak_in_flight);
                error_count++;
            end
        end
        finish_run(1'b0);
    end

    initial begin
        cycle_count = 0;
        wait (trace_loaded);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with %0d of %0d operations committed",
                 cycle_limit, commit_count, total_ops);
        finish_run(1'b1);
    end

endmodule
